// File: rtl/joiner_pkg.sv
package joiner_pkg;

  // Default geometry of the joiner
  localparam int DEFAULT_CHANNELS = 3;
  localparam int DEFAULT_DATA_WIDTH = 16;

  // Bits needed to index a channel, never less than one
  function automatic int index_width(input int channels);
    return (channels > 2) ? $clog2(channels) : 1;
  endfunction

  // Controller states
  typedef enum logic [1:0] {
    JOIN_IDLE,
    JOIN_OPERATE,
    JOIN_ERROR,
    JOIN_DONE
  } join_state_e;

endpackage

// File: rtl/arb_if.sv
`timescale 1ns/100ps

interface arb_if import joiner_pkg::*; #(
  parameter int CHANNELS = DEFAULT_CHANNELS
) ();

  localparam int INDEX_WIDTH = index_width(CHANNELS);

  // Remaining channels of the current operation
  logic [CHANNELS-1:0]    request;
  // Last beat of a channel accepted
  logic [CHANNELS-1:0]    acknowledge;
  logic [CHANNELS-1:0]    grant;
  logic                   grant_valid;
  logic [INDEX_WIDTH-1:0] grant_index;

  modport ctrl (
    output request,
    input  acknowledge
  );

  modport arb (
    input  request,
    input  acknowledge,
    output grant,
    output grant_valid,
    output grant_index
  );

  modport mux (
    input  request,
    output acknowledge,
    input  grant,
    input  grant_valid,
    input  grant_index
  );

endinterface

// File: rtl/stream_if.sv
`timescale 1ns/100ps

interface stream_if import joiner_pkg::*; #(
  parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) ();

  localparam int KEEP_WIDTH = (DATA_WIDTH + 7) / 8;

  logic [DATA_WIDTH-1:0] data;
  logic [KEEP_WIDTH-1:0] keep;
  logic                  valid;
  logic                  ready;
  logic                  last;
  // Beat closes the whole joined packet
  logic                  final_beat;

  modport src (
    output data,
    output keep,
    output valid,
    input  ready,
    output last,
    output final_beat
  );

  modport dst (
    input  data,
    input  keep,
    input  valid,
    output ready,
    input  last,
    input  final_beat
  );

endinterface

// File: rtl/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter import joiner_pkg::*; #(
  parameter int CHANNELS = DEFAULT_CHANNELS
) (
  input  logic clk,
  input  logic int_rst,
  input  logic restart,
  arb_if.arb   arb
);

  localparam int IW = index_width(CHANNELS);

  // Channels strictly above the last grant
  logic [CHANNELS-1:0] prio_mask;
  logic [CHANNELS-1:0] eligible;
  logic [CHANNELS-1:0] pick;
  logic [CHANNELS-1:0] next_grant;
  logic [CHANNELS-1:0] next_above;
  logic [IW-1:0]       next_index;
  logic                grant_acked;

  assign eligible = arb.request & prio_mask;

  // Wrap to the full request set when nothing is left above
  assign pick = (|eligible) ? eligible : arb.request;

  assign grant_acked = |(arb.acknowledge & arb.grant);

  // Lowest set bit wins
  always_comb begin
    next_index = '0;
    for (int i = CHANNELS - 1; i >= 0; i--) begin
      if (pick[i]) begin
        next_index = IW'(i);
      end
    end
  end

  always_comb begin
    next_grant = '0;
    next_above = '0;
    for (int i = 0; i < CHANNELS; i++) begin
      next_grant[i] = pick[i] && (i == int'(next_index));
      next_above[i] = (i > int'(next_index));
    end
  end

  always_ff @(posedge clk) begin
    if (int_rst || restart) begin
      arb.grant       <= '0;
      arb.grant_valid <= 1'b0;
      arb.grant_index <= '0;
      prio_mask       <= '1;
    end else if (arb.grant_valid) begin
      // Blocking: hold until the granted channel is acknowledged
      if (grant_acked) begin
        arb.grant       <= '0;
        arb.grant_valid <= 1'b0;
      end
    end else if (|arb.request) begin
      arb.grant       <= next_grant;
      arb.grant_valid <= 1'b1;
      arb.grant_index <= next_index;
      prio_mask       <= next_above;
    end
  end

endmodule

// File: rtl/stream_mux.sv
`timescale 1ns/100ps

module stream_mux import joiner_pkg::*; #(
  parameter int CHANNELS = DEFAULT_CHANNELS,
  parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
  localparam int KEEP_WIDTH = (DATA_WIDTH + 7) / 8
) (
  input  logic                           clk,
  input  logic                           int_rst,
  input  logic                           gate_open,
  arb_if.mux                             arb,

  input  logic [CHANNELS*DATA_WIDTH-1:0] s_tdata,
  input  logic [CHANNELS*KEEP_WIDTH-1:0] s_tkeep,
  input  logic [CHANNELS-1:0]            s_tvalid,
  input  logic [CHANNELS-1:0]            s_tlast,
  output logic [CHANNELS-1:0]            s_tready,

  output logic [DATA_WIDTH-1:0]          m_tdata,
  output logic [KEEP_WIDTH-1:0]          m_tkeep,
  output logic                           m_tvalid,
  output logic                           m_tlast,
  input  logic                           m_tready,

  output logic                           final_sent
);

  stream_if #(.DATA_WIDTH(DATA_WIDTH)) beat ();

  logic path_open;
  logic beat_taken;
  logic out_final;

  // Selector half

  assign path_open = gate_open & arb.grant_valid;

  assign beat.data  = s_tdata[arb.grant_index*DATA_WIDTH +: DATA_WIDTH];
  assign beat.keep  = s_tkeep[arb.grant_index*KEEP_WIDTH +: KEEP_WIDTH];
  assign beat.last  = s_tlast[arb.grant_index];
  assign beat.valid = path_open & s_tvalid[arb.grant_index] & arb.request[arb.grant_index];

  // Only the granted, still requested channel sees ready
  assign s_tready = {CHANNELS{path_open & beat.ready}} & arb.grant & arb.request;

  assign beat_taken = beat.valid & beat.ready;

  assign arb.acknowledge = {CHANNELS{beat_taken & beat.last}} & arb.grant;

  // Nothing left to collect once this channel is acknowledged
  assign beat.final_beat = beat.last & ((arb.request & ~arb.acknowledge) == '0);

  // Output register half

  // Takes a new beat while handing off the held one
  assign beat.ready = ~m_tvalid | m_tready;

  always_ff @(posedge clk) begin
    if (int_rst) begin
      m_tvalid <= 1'b0;
    end else if (beat.ready) begin
      m_tvalid <= beat.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_taken) begin
      m_tdata   <= beat.data;
      m_tkeep   <= beat.keep;
      out_final <= beat.final_beat;
    end
  end

  // Inner packet ends are swallowed
  assign m_tlast = out_final;

  assign final_sent = m_tvalid & m_tready & out_final;

endmodule

// File: rtl/join_control.sv
`timescale 1ns/100ps

module joiner_control import joiner_pkg::*; #(
  parameter int CHANNELS = DEFAULT_CHANNELS
) (
  input  logic                clk,
  input  logic                int_rst,
  input  logic                operation_start,
  input  logic [CHANNELS-1:0] use_channels,
  input  logic                lock,
  input  logic                interrupt,
  input  logic                final_sent,
  arb_if.ctrl                 arb,
  output logic                gate_open,
  output logic                operation_busy,
  output logic                operation_complete,
  output logic                operation_error
);

  join_state_e         state;
  join_state_e         state_next;
  logic [CHANNELS-1:0] mask;
  // Final beat left while the state was frozen by lock
  logic                tail_sent;
  logic                entering;

  always_comb begin
    state_next = state;
    if (!lock) begin
      case (state)
        JOIN_IDLE, JOIN_DONE: begin
          if (operation_start) begin
            state_next = (|use_channels) ? JOIN_OPERATE : JOIN_ERROR;
          end else begin
            state_next = JOIN_IDLE;
          end
        end
        JOIN_OPERATE: begin
          if (final_sent || tail_sent) begin
            state_next = JOIN_DONE;
          end
        end
        JOIN_ERROR: begin
          state_next = JOIN_IDLE;
        end
        default: begin
          state_next = JOIN_IDLE;
        end
      endcase
    end
    // Interrupt overrides lock
    if (interrupt) begin
      state_next = JOIN_IDLE;
    end
  end

  assign entering = (state_next == JOIN_OPERATE) && (state != JOIN_OPERATE);

  always_ff @(posedge clk) begin
    if (int_rst) begin
      state              <= JOIN_IDLE;
      mask               <= '0;
      tail_sent          <= 1'b0;
      operation_busy     <= 1'b0;
      operation_complete <= 1'b0;
      operation_error    <= 1'b0;
    end else begin
      state              <= state_next;
      operation_busy     <= (state_next == JOIN_OPERATE);
      operation_complete <= (state == JOIN_OPERATE) && (state_next == JOIN_DONE);
      operation_error    <= (state != JOIN_ERROR) && (state_next == JOIN_ERROR);

      if (entering) begin
        mask      <= use_channels;
        tail_sent <= 1'b0;
      end else if (state_next == JOIN_OPERATE) begin
        // Drop channels whose packet is in
        mask <= mask & ~arb.acknowledge;
        if (final_sent) begin
          tail_sent <= 1'b1;
        end
      end else begin
        mask      <= '0;
        tail_sent <= 1'b0;
      end
    end
  end

  assign arb.request = mask;

  // Lock only holds off inputs between operations
  assign gate_open = operation_busy | ~lock;

endmodule

// File: rtl/packet_joiner.sv
`timescale 1ns/100ps

module packet_joiner import joiner_pkg::*; #(
  parameter int CHANNELS = DEFAULT_CHANNELS,
  parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
  localparam int KEEP_WIDTH = (DATA_WIDTH + 7) / 8
) (
  input  logic                           clk,
  input  logic                           int_rst,

  input  logic                           operation_start,
  input  logic [CHANNELS-1:0]            use_channels,
  input  logic                           lock,
  input  logic                           interrupt,

  output logic                           operation_busy,
  output logic                           operation_complete,
  output logic                           operation_error,
  output logic                           transmission,

  input  logic [CHANNELS*DATA_WIDTH-1:0] s_tdata,
  input  logic [CHANNELS*KEEP_WIDTH-1:0] s_tkeep,
  input  logic [CHANNELS-1:0]            s_tvalid,
  output logic [CHANNELS-1:0]            s_tready,
  input  logic [CHANNELS-1:0]            s_tlast,

  output logic [DATA_WIDTH-1:0]          m_tdata,
  output logic [KEEP_WIDTH-1:0]          m_tkeep,
  output logic                           m_tvalid,
  input  logic                           m_tready,
  output logic                           m_tlast
);

  logic block_rst;
  logic gate_open;
  logic final_sent;

  // Interrupt flushes arbiter and output register
  assign block_rst = int_rst | interrupt;

  arb_if #(.CHANNELS(CHANNELS)) arb ();

  joiner_control #(
    .CHANNELS(CHANNELS)
  ) i_joiner_control (
    .clk                (clk),
    .int_rst            (int_rst),
    .operation_start    (operation_start),
    .use_channels       (use_channels),
    .lock               (lock),
    .interrupt          (interrupt),
    .final_sent         (final_sent),
    .arb                (arb.ctrl),
    .gate_open          (gate_open),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error)
  );

  // Complete pulse marks the done state, next operation starts at channel 0
  rr_arbiter #(
    .CHANNELS(CHANNELS)
  ) i_rr_arbiter (
    .clk     (clk),
    .int_rst (block_rst),
    .restart (operation_complete),
    .arb     (arb.arb)
  );

  stream_mux #(
    .CHANNELS   (CHANNELS),
    .DATA_WIDTH (DATA_WIDTH)
  ) i_stream_mux (
    .clk        (clk),
    .int_rst    (block_rst),
    .gate_open  (gate_open),
    .arb        (arb.mux),
    .s_tdata    (s_tdata),
    .s_tkeep    (s_tkeep),
    .s_tvalid   (s_tvalid),
    .s_tlast    (s_tlast),
    .s_tready   (s_tready),
    .m_tdata    (m_tdata),
    .m_tkeep    (m_tkeep),
    .m_tvalid   (m_tvalid),
    .m_tlast    (m_tlast),
    .m_tready   (m_tready),
    .final_sent (final_sent)
  );

  // High the cycle after each output handshake
  always_ff @(posedge clk) begin
    if (int_rst) begin
      transmission <= 1'b0;
    end else begin
      transmission <= m_tvalid & m_tready;
    end
  end

endmodule

// File: verif/packet_joiner_tb.sv
`timescale 1ns/100ps

module packet_joiner_tb import joiner_pkg::*;;

  localparam int CH = DEFAULT_CHANNELS;
  localparam int DW = DEFAULT_DATA_WIDTH;
  localparam int KW = (DW + 7) / 8;

  logic              clk = 1'b0;
  logic              int_rst = 1'b1;
  logic              operation_start = 1'b0;
  logic [CH-1:0]     use_channels = '0;
  logic              lock = 1'b0;
  logic              interrupt = 1'b0;
  logic              operation_busy, operation_complete, operation_error, transmission;
  logic [CH*DW-1:0]  s_tdata = '0;
  logic [CH*KW-1:0]  s_tkeep = '0;
  logic [CH-1:0]     s_tvalid = '0;
  logic [CH-1:0]     s_tready;
  logic [CH-1:0]     s_tlast = '0;
  logic [DW-1:0]     m_tdata;
  logic [KW-1:0]     m_tkeep;
  logic              m_tvalid, m_tlast;
  logic              m_tready = 1'b0;

  // Test table from the stimulus file
  string       t_name [0:31];
  logic [CH-1:0] t_mask [0:31];
  int          t_len [0:31][0:CH-1];
  int          t_pct [0:31], t_lock [0:31], t_irq [0:31];
  int          num_tests = 0;

  // Source models, sink and scoreboard state
  logic [CH-1:0] src_mask;
  int          src_len [0:CH-1];
  int          src_idx [0:CH-1];
  int          ready_pct;
  logic [DW-1:0] expected_q[$];
  integer      seed = 32'h34b81461;
  int          limit = 0;
  int          run_cycles = 0;
  int          tb_cycle, last_final_cycle;
  int          beat_count, last_count, tx_count, complete_count, error_count;
  int          exp_beats;
  bit          busy_seen, start_now, irq_now, lock_now;
  string       cur_name;
  int          test_errors, tests_passed = 0, tests_failed = 0;

  packet_joiner #(.CHANNELS(CH), .DATA_WIDTH(DW)) i_packet_joiner (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (limit > 0 && run_cycles >= limit) begin
      $display("Timeout after %0d cycles in test %s, the DUT stopped responding",
               run_cycles, cur_name);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected %0h actual %0h", cur_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // One summary line per finished test
  task automatic record_result();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: ok, %0d beats", cur_name, beat_count);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_name, test_errors);
    end
  endtask

  // Sample at the edge, then drive inputs shortly after
  task automatic cycle();
    logic [DW-1:0] exp_data;
    integer rnd;
    @(posedge clk);
    for (int c = 0; c < CH; c++) begin
      if (s_tvalid[c] && s_tready[c]) begin
        src_idx[c]++;
      end
    end
    if (m_tvalid && m_tready) begin
      beat_count++;
      if (expected_q.size() == 0) begin
        $display("FAIL %s: output beat %0h arrived with none expected", cur_name, m_tdata);
        test_errors++;
      end else begin
        exp_data = expected_q.pop_front();
        check_value("data", 32'(exp_data), 32'(m_tdata));
        check_value("keep", 32'({KW{1'b1}}), 32'(m_tkeep));
        check_value("last", 32'(expected_q.size() == 0), 32'(m_tlast));
        if (expected_q.size() == 0) begin
          last_final_cycle = tb_cycle;
        end
      end
      if (m_tlast) begin
        last_count++;
      end
    end
    if (transmission) tx_count++;
    if (operation_error) error_count++;
    if (operation_busy) busy_seen = 1'b1;
    if (operation_complete) begin
      complete_count++;
      check_value("complete delay", last_final_cycle + 1, tb_cycle);
    end
    tb_cycle++;
    #2;
    for (int c = 0; c < CH; c++) begin
      s_tvalid[c] = src_mask[c] && (src_idx[c] < src_len[c]);
      s_tdata[c*DW +: DW] = {8'(c), 8'(src_idx[c])};
      s_tkeep[c*KW +: KW] = '1;
      s_tlast[c] = (src_idx[c] == src_len[c] - 1);
    end
    rnd = $random(seed);
    m_tready = ((rnd & 32'h7fffffff) % 100) < ready_pct;
    operation_start = start_now;
    interrupt = irq_now;
    lock = lock_now;
    start_now = 1'b0;
    irq_now = 1'b0;
  endtask

  task automatic read_stimulus();
    int fd;
    string line;
    int n;
    fd = $fopen("verif/packet_joiner_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %b %d %d %d %d %d %d", t_name[num_tests],
                      t_mask[num_tests], t_len[num_tests][0], t_len[num_tests][1],
                      t_len[num_tests][2], t_pct[num_tests], t_lock[num_tests],
                      t_irq[num_tests]);
          if (n == 8) num_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int t);
    cur_name = t_name[t];
    test_errors = 0;
    beat_count = 0;
    last_count = 0;
    tx_count = 0;
    complete_count = 0;
    error_count = 0;
    busy_seen = 1'b0;
    last_final_cycle = -10;
    expected_q.delete();
    ready_pct = t_pct[t];
    src_mask = t_mask[t];
    // Selected channels in ascending order, each packet whole
    for (int c = 0; c < CH; c++) begin
      src_len[c] = t_len[t][c];
      src_idx[c] = 0;
      if (t_mask[t][c]) begin
        for (int b = 0; b < t_len[t][c]; b++) expected_q.push_back({8'(c), 8'(b)});
      end
    end
    exp_beats = expected_q.size();
    if (t_lock[t] != 0) begin
      lock_now = 1'b1;
      use_channels = t_mask[t];
      // A start while locked must not begin an operation
      start_now = 1'b1;
      repeat (10) begin
        cycle();
        check_value("s_tready under lock", 0, 32'(s_tready));
        check_value("m_tvalid under lock", 0, 32'(m_tvalid));
      end
      check_value("busy under lock", 0, 32'(busy_seen));
      lock_now = 1'b0;
      cycle();
    end
    use_channels = t_mask[t];
    start_now = 1'b1;
    cycle();
    if (t_mask[t] == '0) begin
      repeat (10) cycle();
      check_value("error pulses", 1, error_count);
      check_value("busy seen", 0, 32'(busy_seen));
      check_value("output beats", 0, beat_count);
    end else if (t_irq[t] != 0) begin
      while (beat_count < 3) cycle();
      irq_now = 1'b1;
      cycle();
      src_mask = '0;
      repeat (10) cycle();
      check_value("busy after interrupt", 0, 32'(operation_busy));
      check_value("complete pulses", 0, complete_count);
    end else begin
      while (complete_count == 0) cycle();
      repeat (5) cycle();
      check_value("complete pulses", 1, complete_count);
      check_value("busy seen", 1, 32'(busy_seen));
      check_value("busy at end", 0, 32'(operation_busy));
      check_value("beats left", 0, expected_q.size());
      check_value("output beats", exp_beats, beat_count);
      check_value("last beats", 1, last_count);
      check_value("transmission cycles", exp_beats, tx_count);
    end
    src_mask = '0;
    cycle();
    record_result();
  endtask

  initial begin
    int total;
    src_mask = '0;
    ready_pct = 100;
    start_now = 1'b0;
    irq_now = 1'b0;
    lock_now = 1'b0;
    tb_cycle = 0;
    for (int c = 0; c < CH; c++) begin
      src_len[c] = 0;
      src_idx[c] = 0;
    end
    cur_name = "reset";
    read_stimulus();
    total = 0;
    for (int t = 0; t < num_tests; t++) begin
      total += 200 + 20 * (t_len[t][0] + t_len[t][1] + t_len[t][2]);
    end
    limit = total;
    repeat (16) @(posedge clk);
    #2;
    int_rst = 1'b0;
    test_errors = 0;
    check_value("busy after reset", 0, 32'(operation_busy));
    check_value("complete after reset", 0, 32'(operation_complete));
    check_value("error after reset", 0, 32'(operation_error));
    check_value("transmission after reset", 0, 32'(transmission));
    check_value("m_tvalid after reset", 0, 32'(m_tvalid));
    check_value("s_tready after reset", 0, 32'(s_tready));
    record_result();
    if (num_tests == 0) begin
      $display("No tests found in the stimulus file");
      tests_failed++;
    end
    for (int t = 0; t < num_tests; t++) run_test(t);
    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: verif/packet_joiner_stimulus.txt
# name mask(binary, ch2..ch0) len_ch0 len_ch1 len_ch2 ready_percent lock interrupt
# lengths of unselected channels are ignored
concat_101 101 4 0 3 100 0 0
concat_111 111 2 5 1 100 0 0
single_010 010 0 6 0 100 0 0
zero_mask 000 0 0 0 100 0 0
after_zero 011 3 2 0 100 0 0
backpressure_111 111 6 3 4 50 0 0
backpressure_110 110 0 7 5 30 0 0
lock_011 011 3 2 0 100 1 0
lock_100 100 0 0 4 60 1 0
interrupt_111 111 5 5 5 100 0 1
after_interrupt 111 4 2 3 70 0 0
short_beats 111 1 1 1 80 0 0

// File: packet_joiner.f
rtl/joiner_pkg.sv
rtl/arb_if.sv
rtl/stream_if.sv
rtl/rr_arbiter.sv
rtl/stream_mux.sv
rtl/join_control.sv
rtl/packet_joiner.sv
verif/packet_joiner_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the packet joiner testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f packet_joiner.f \
	  --top-module packet_joiner_tb -Mdir obj_dir
	./obj_dir/Vpacket_joiner_tb | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
